//--- mem_queue_config.svh
`ifndef MEM_QUEUE_CONFIG_SVH
`define MEM_QUEUE_CONFIG_SVH

// one queue entry holds a full request word
`define REQ_WIDTH   64

// number of queue entries, power of two
`define QUEUE_SIZE  4

// word address into the scratchpad, 64 words
`define ADDR_WIDTH  6

// scratchpad data word
`define DATA_WIDTH  32

// read tag, wraps at 256
`define TAG_WIDTH   8

`endif

//--- mem_request_pkg.sv
`include "mem_queue_config.svh"

package mem_request_pkg;

    typedef enum logic [1:0]
    {
        OP_IDLE  = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b10
    } req_opcode_t;

    // filler between the used fields of each view
    localparam int READ_PAD_WIDTH  = `REQ_WIDTH - 2 - `TAG_WIDTH - `ADDR_WIDTH;
    localparam int WRITE_PAD_WIDTH = `REQ_WIDTH - 2 - `DATA_WIDTH - `ADDR_WIDTH;

    // opcode sits in the top two bits of both views
    typedef struct packed
    {
        req_opcode_t                 opcode;
        logic [`TAG_WIDTH-1:0]       tag;
        logic [READ_PAD_WIDTH-1:0]   unused;
        logic [`ADDR_WIDTH-1:0]      addr;
    } read_req_t;

    typedef struct packed
    {
        req_opcode_t                 opcode;
        logic [WRITE_PAD_WIDTH-1:0]  unused;
        logic [`DATA_WIDTH-1:0]      data;
        logic [`ADDR_WIDTH-1:0]      addr;
    } write_req_t;

    // decode the opcode first, then pick the view
    typedef union packed
    {
        read_req_t   rd;
        write_req_t  wr;
    } mem_request_t;

endpackage

//--- mem_response_pkg.sv
`include "mem_queue_config.svh"

package mem_response_pkg;

    // tag handed out by the packer, returned with the read data
    typedef logic [`TAG_WIDTH-1:0]  resp_tag_t;

    // one scratchpad word
    typedef logic [`DATA_WIDTH-1:0] resp_data_t;

endpackage

//--- fifo_queue.sv
`timescale 1ns/1ps

`include "mem_queue_config.svh"

module fifo_queue
#(
    parameter int WIDTH      = `REQ_WIDTH,
    parameter int QUEUE_SIZE = `QUEUE_SIZE
)
(
    input  logic                clk_in,
    input  logic                reset_in,

    output logic                is_empty,
    output logic                is_full,

    input  logic [WIDTH-1:0]    request_in,
    input  logic                request_valid_in,
    output logic                issue_ack_out,

    output logic [WIDTH-1:0]    request_out,
    output logic                request_valid_out,
    input  logic                issue_ack_in
);

localparam int PTR_WIDTH = $clog2(QUEUE_SIZE);

logic [WIDTH-1:0]       storage [QUEUE_SIZE];
logic [WIDTH-1:0]       storage_output;
logic [QUEUE_SIZE-1:0]  entry_valid;

logic [PTR_WIDTH-1:0]   write_ptr;
logic [PTR_WIDTH-1:0]   read_ptr;
logic [PTR_WIDTH-1:0]   next_write_ptr;
logic [PTR_WIDTH-1:0]   next_read_ptr;

logic                   write_en;
logic                   head_done;
logic                   head_bypass;
logic                   head_valid_next;

// power-of-two depth, so pointers wrap on overflow
assign next_write_ptr = write_ptr + 1'b1;
assign next_read_ptr  = read_ptr + 1'b1;

assign is_full  = &entry_valid;
assign is_empty = ~|entry_valid;

// also high when a full queue completes its head this cycle
assign issue_ack_out = ~is_full | (issue_ack_in & request_valid_out);

assign write_en  = request_valid_in & issue_ack_out;
assign head_done = issue_ack_in & request_valid_out & entry_valid[read_ptr];

// head slot empty but written right now
assign head_bypass = ~entry_valid[read_ptr] & write_en & (write_ptr == read_ptr);

// valid drops for one cycle after every completion
assign head_valid_next = ~head_done & (entry_valid[read_ptr] | head_bypass);

// look ahead past the slot that is completing
assign storage_output = storage[head_done ? next_read_ptr : read_ptr];

always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        write_ptr         <= '0;
        read_ptr          <= '0;
        request_valid_out <= 1'b0;
    end
    else
    begin
        if (write_en)
        begin
            write_ptr <= next_write_ptr;
        end

        if (head_done)
        begin
            read_ptr <= next_read_ptr;
        end

        request_valid_out <= head_valid_next;
    end
end

always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        entry_valid <= '0;
    end
    else
    begin
        for (int i = 0; i < QUEUE_SIZE; i++)
        begin
            // a write into the completing slot keeps it valid
            if (write_en && write_ptr == PTR_WIDTH'(i))
            begin
                entry_valid[i] <= 1'b1;
            end
            else if (head_done && read_ptr == PTR_WIDTH'(i))
            begin
                entry_valid[i] <= 1'b0;
            end
        end
    end
end

// flip-flop storage
always_ff @(posedge clk_in)
begin
    if (write_en)
    begin
        storage[write_ptr] <= request_in;
    end
end

// registered head
always_ff @(posedge clk_in)
begin
    if (head_bypass)
    begin
        request_out <= request_in;
    end
    else
    begin
        request_out <= storage_output;
    end
end

endmodule

//--- request_packer.sv
`timescale 1ns/1ps

`include "mem_queue_config.svh"

module request_packer
(
    input  logic                          clk_in,
    input  logic                          reset_in,

    input  logic                          cmd_valid,
    input  logic                          cmd_write,
    input  logic [`ADDR_WIDTH-1:0]        cmd_addr,
    input  logic [`DATA_WIDTH-1:0]        cmd_data,
    output logic                          cmd_ack,

    input  logic                          queue_ack,
    output mem_request_pkg::mem_request_t request_word,
    output logic                          request_valid
);

import mem_request_pkg::*;
import mem_response_pkg::*;

resp_tag_t tag_count;

assign cmd_ack       = queue_ack;
assign request_valid = cmd_valid;

always_comb
begin
    if (!cmd_valid)
    begin
        request_word = '0;
    end
    else if (cmd_write)
    begin
        request_word.wr.opcode = OP_WRITE;
        request_word.wr.unused = '0;
        request_word.wr.data   = cmd_data;
        request_word.wr.addr   = cmd_addr;
    end
    else
    begin
        request_word.rd.opcode = OP_READ;
        request_word.rd.tag    = tag_count;
        request_word.rd.unused = '0;
        request_word.rd.addr   = cmd_addr;
    end
end

// only accepted reads take a tag
always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        tag_count <= '0;
    end
    else if (cmd_valid && cmd_ack && !cmd_write)
    begin
        tag_count <= tag_count + 1'b1;
    end
end

endmodule

//--- scratchpad_memory.sv
`timescale 1ns/1ps

`include "mem_queue_config.svh"

module scratchpad_memory
(
    input  logic                           clk_in,
    input  logic                           reset_in,

    input  mem_request_pkg::mem_request_t  request_word,
    input  logic                           request_valid,
    input  logic                           busy,
    output logic                           issue_ack,

    output logic                           resp_valid,
    output mem_response_pkg::resp_tag_t    resp_tag,
    output mem_response_pkg::resp_data_t   resp_data
);

import mem_request_pkg::*;
import mem_response_pkg::*;

localparam int MEM_WORDS = 1 << `ADDR_WIDTH;

resp_data_t  mem [MEM_WORDS];
req_opcode_t opcode;
logic        do_read;
logic        do_write;

// same top bits in either view
assign opcode = request_word.rd.opcode;

assign issue_ack = request_valid & ~busy;

always_comb
begin
    do_read  = 1'b0;
    do_write = 1'b0;
    case (opcode)
        OP_READ:
        begin
            do_read = issue_ack;
        end
        OP_WRITE:
        begin
            do_write = issue_ack;
        end
        default:
        begin
            do_read  = 1'b0;
            do_write = 1'b0;
        end
    endcase
end

always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        resp_valid <= 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i] <= '0;
        end
    end
    else
    begin
        resp_valid <= do_read;
        if (do_write)
        begin
            mem[request_word.wr.addr] <= request_word.wr.data;
        end
    end
end

// response payload, qualified by resp_valid
always_ff @(posedge clk_in)
begin
    if (do_read)
    begin
        resp_tag  <= request_word.rd.tag;
        resp_data <= mem[request_word.rd.addr];
    end
end

endmodule

//--- mem_queue_top.sv
`timescale 1ns/1ps

`include "mem_queue_config.svh"

module mem_queue_top
(
    input  logic                          clk_in,
    input  logic                          reset_in,

    input  logic                          cmd_valid,
    input  logic                          cmd_write,
    input  logic [`ADDR_WIDTH-1:0]        cmd_addr,
    input  logic [`DATA_WIDTH-1:0]        cmd_data,
    output logic                          cmd_ack,

    input  logic                          busy,

    output logic                          is_empty,
    output logic                          is_full,

    output logic                          resp_valid,
    output mem_response_pkg::resp_tag_t   resp_tag,
    output mem_response_pkg::resp_data_t  resp_data
);

import mem_request_pkg::*;

mem_request_t packed_word;
mem_request_t head_word;
logic         packed_valid;
logic         head_valid;
logic         queue_ack;
logic         head_ack;

request_packer i_request_packer
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .cmd_valid      (cmd_valid),
    .cmd_write      (cmd_write),
    .cmd_addr       (cmd_addr),
    .cmd_data       (cmd_data),
    .cmd_ack        (cmd_ack),
    .queue_ack      (queue_ack),
    .request_word   (packed_word),
    .request_valid  (packed_valid)
);

fifo_queue
#(
    .WIDTH          (`REQ_WIDTH),
    .QUEUE_SIZE     (`QUEUE_SIZE)
)
i_fifo_queue
(
    .clk_in             (clk_in),
    .reset_in           (reset_in),
    .is_empty           (is_empty),
    .is_full            (is_full),
    .request_in         (packed_word),
    .request_valid_in   (packed_valid),
    .issue_ack_out      (queue_ack),
    .request_out        (head_word),
    .request_valid_out  (head_valid),
    .issue_ack_in       (head_ack)
);

scratchpad_memory i_scratchpad_memory
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .request_word   (head_word),
    .request_valid  (head_valid),
    .busy           (busy),
    .issue_ack      (head_ack),
    .resp_valid     (resp_valid),
    .resp_tag       (resp_tag),
    .resp_data      (resp_data)
);

endmodule

//--- mem_queue_chk.sv
`timescale 1ns/1ps

`include "mem_queue_config.svh"

module mem_queue_chk
#(
    parameter int WIDTH     = `REQ_WIDTH,
    parameter int PTR_WIDTH = $clog2(`QUEUE_SIZE)
)
(
    input logic                 clk_in,
    input logic                 reset_in,
    input logic                 is_empty,
    input logic                 is_full,
    input logic [WIDTH-1:0]     request_out,
    input logic                 request_valid_out,
    input logic                 issue_ack_in,
    input logic [PTR_WIDTH-1:0] write_ptr
);

int error_count = 0;

// a valid head is always a stored entry
head_not_empty: assert property (@(posedge clk_in) disable iff (reset_in)
    !(is_empty && request_valid_out))
else
begin
    error_count++;
    $error("queue reports empty while its head is valid");
end

// one bubble after every completed head
valid_drops_after_ack: assert property (@(posedge clk_in) disable iff (reset_in)
    request_valid_out && issue_ack_in |=> !request_valid_out)
else
begin
    error_count++;
    $error("head stayed valid in the cycle after its ack");
end

head_stable: assert property (@(posedge clk_in) disable iff (reset_in)
    request_valid_out && !issue_ack_in |=> $stable(request_out))
else
begin
    error_count++;
    $error("head word changed while valid and not acknowledged");
end

// write pointer holds while full and the head is not taken
no_write_when_full: assert property (@(posedge clk_in) disable iff (reset_in)
    is_full && !(request_valid_out && issue_ack_in) |=> $stable(write_ptr))
else
begin
    error_count++;
    $error("request taken into a full queue without a head ack");
end

endmodule

bind fifo_queue mem_queue_chk
#(
    .WIDTH              (WIDTH),
    .PTR_WIDTH          (PTR_WIDTH)
)
i_mem_queue_chk
(
    .clk_in             (clk_in),
    .reset_in           (reset_in),
    .is_empty           (is_empty),
    .is_full            (is_full),
    .request_out        (request_out),
    .request_valid_out  (request_valid_out),
    .issue_ack_in       (issue_ack_in),
    .write_ptr          (write_ptr)
);

//--- mem_queue_tb.sv
`timescale 1ns/1ps

`include "mem_queue_config.svh"

module mem_queue_tb;

import mem_request_pkg::*;
import mem_response_pkg::*;

localparam int NUM_RANDOM     = 600;
localparam int MAX_BUSY       = 8;
localparam int TOTAL_CMDS     = NUM_RANDOM + 16;
localparam int TIMEOUT_CYCLES = 2 * TOTAL_CMDS * MAX_BUSY;

logic                   clk_in;
logic                   reset_in;
logic                   cmd_valid;
logic                   cmd_write;
logic [`ADDR_WIDTH-1:0] cmd_addr;
logic [`DATA_WIDTH-1:0] cmd_data;
logic                   cmd_ack;
logic                   busy;
logic                   is_empty;
logic                   is_full;
logic                   resp_valid;
resp_tag_t              resp_tag;
resp_data_t             resp_data;

integer     seed;
int         cycle_count;
string      test_name;
resp_data_t model_mem [1 << `ADDR_WIDTH];
resp_tag_t  model_tag;
resp_tag_t  exp_tags [$];
resp_data_t exp_data [$];

mem_queue_top i_mem_queue_top
(
    .clk_in     (clk_in),
    .reset_in   (reset_in),
    .cmd_valid  (cmd_valid),
    .cmd_write  (cmd_write),
    .cmd_addr   (cmd_addr),
    .cmd_data   (cmd_data),
    .cmd_ack    (cmd_ack),
    .busy       (busy),
    .is_empty   (is_empty),
    .is_full    (is_full),
    .resp_valid (resp_valid),
    .resp_tag   (resp_tag),
    .resp_data  (resp_data)
);

initial
begin
    clk_in = 1'b0;
    forever
    begin
        #5 clk_in = ~clk_in;
    end
end

task fail_and_stop(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1);
endtask

task compare_tag(input string what, input resp_tag_t expected, input resp_tag_t actual);
    if (actual !== expected)
    begin
        fail_and_stop($sformatf("Fail %s %s: expected %0h, actual %0h",
                                test_name, what, expected, actual));
    end
endtask

task compare_data(input string what, input resp_data_t expected, input resp_data_t actual);
    if (actual !== expected)
    begin
        fail_and_stop($sformatf("Fail %s %s: expected %0h, actual %0h",
                                test_name, what, expected, actual));
    end
endtask

task compare_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
        fail_and_stop($sformatf("Fail %s %s: expected %0b, actual %0b",
                                test_name, what, expected, actual));
    end
endtask

// model follows acceptance order since the queue keeps it
task accept_cmd;
    if (cmd_write)
    begin
        model_mem[cmd_addr] = cmd_data;
    end
    else
    begin
        exp_tags.push_back(model_tag);
        exp_data.push_back(model_mem[cmd_addr]);
        model_tag = model_tag + 1'b1;
    end
endtask

task make_random_cmd;
    req_opcode_t op;
    op = ($random(seed) & 1) ? OP_WRITE : OP_READ;
    cmd_write = (op == OP_WRITE);
    cmd_addr  = $random(seed);
    cmd_data  = $random(seed);
    cmd_valid = 1'b1;
endtask

// hold the command until the DUT takes it
task wait_taken;
    logic taken;
    taken = 1'b0;
    while (!taken)
    begin
        @(negedge clk_in);
        if (cmd_ack)
        begin
            accept_cmd();
            taken = 1'b1;
        end
        @(posedge clk_in);
        #1;
    end
endtask

task send_cmd(input logic write, input logic [`ADDR_WIDTH-1:0] addr,
              input logic [`DATA_WIDTH-1:0] data);
    cmd_write = write;
    cmd_addr  = addr;
    cmd_data  = data;
    cmd_valid = 1'b1;
    wait_taken();
    cmd_valid = 1'b0;
endtask

task wait_drain;
    @(negedge clk_in);
    while (exp_tags.size() != 0 || !is_empty)
    begin
        @(negedge clk_in);
    end
    compare_flag("is_full", 1'b0, is_full);
    compare_flag("cmd_ack", 1'b1, cmd_ack);
    @(posedge clk_in);
    #1;
endtask

task fill_under_busy;
    int   accepted;
    logic taken;
    accepted = 0;
    busy = 1'b1;
    make_random_cmd();
    repeat (`QUEUE_SIZE + 4)
    begin
        @(negedge clk_in);
        taken = cmd_ack;
        if (taken)
        begin
            accept_cmd();
            accepted++;
        end
        @(posedge clk_in);
        #1;
        if (taken)
        begin
            make_random_cmd();
        end
    end
    if (accepted != `QUEUE_SIZE)
    begin
        fail_and_stop($sformatf("Fail %s accepted: expected %0d, actual %0d",
                                test_name, `QUEUE_SIZE, accepted));
    end
    @(negedge clk_in);
    compare_flag("is_full", 1'b1, is_full);
    compare_flag("cmd_ack", 1'b0, cmd_ack);
    @(posedge clk_in);
    #1;
    busy = 1'b0;
    // held command goes in once the head moves
    wait_taken();
    cmd_valid = 1'b0;
endtask

task run_random(input int count);
    int   sent;
    int   gap;
    int   busy_left;
    logic taken;
    sent      = 0;
    gap       = 0;
    busy_left = 0;
    taken     = 1'b0;
    while (sent < count)
    begin
        if (taken)
        begin
            cmd_valid = 1'b0;
            taken     = 1'b0;
            gap       = $unsigned($random(seed)) % 4;
        end
        // busy bursts of random level and length
        if (busy_left == 0)
        begin
            busy      = ($unsigned($random(seed)) % 3) == 0;
            busy_left = 1 + $unsigned($random(seed)) % MAX_BUSY;
        end
        busy_left--;
        if (!cmd_valid)
        begin
            if (gap == 0)
            begin
                make_random_cmd();
            end
            else
            begin
                gap--;
            end
        end
        @(negedge clk_in);
        if (cmd_valid && cmd_ack)
        begin
            accept_cmd();
            sent++;
            taken = 1'b1;
        end
        @(posedge clk_in);
        #1;
    end
    cmd_valid = 1'b0;
    busy      = 1'b0;
endtask

// response monitor
initial
begin
    forever
    begin
        @(negedge clk_in);
        if (!reset_in && resp_valid)
        begin
            if (exp_tags.size() == 0)
            begin
                fail_and_stop("a read response arrived with no read outstanding");
            end
            else
            begin
                compare_tag("resp_tag", exp_tags.pop_front(), resp_tag);
                compare_data("resp_data", exp_data.pop_front(), resp_data);
            end
        end
    end
end

initial
begin
    cycle_count = 0;
    forever
    begin
        @(posedge clk_in);
        cycle_count++;
        if (i_mem_queue_top.i_fifo_queue.i_mem_queue_chk.error_count != 0)
        begin
            fail_and_stop("a queue assertion failed");
        end
        else if (cycle_count >= TIMEOUT_CYCLES)
        begin
            fail_and_stop("timeout: the DUT stopped making progress");
        end
    end
end

initial
begin
    seed      = 32'ha4a1_0522;
    reset_in  = 1'b1;
    cmd_valid = 1'b0;
    cmd_write = 1'b0;
    cmd_addr  = '0;
    cmd_data  = '0;
    busy      = 1'b0;
    model_tag = '0;
    test_name = "reset";
    for (int i = 0; i < (1 << `ADDR_WIDTH); i++)
    begin
        model_mem[i] = '0;
    end
    repeat (5) @(posedge clk_in);
    #1;
    reset_in = 1'b0;
    @(negedge clk_in);
    compare_flag("is_empty", 1'b1, is_empty);
    compare_flag("is_full", 1'b0, is_full);
    compare_flag("cmd_ack", 1'b1, cmd_ack);
    repeat (4) @(posedge clk_in);
    #1;

    test_name = "write_then_read";
    send_cmd(1'b1, 5, 32'hcafe_f00d);
    send_cmd(1'b0, 5, '0);
    // never written so it reads zero
    send_cmd(1'b0, 40, '0);
    wait_drain();

    test_name = "busy_fill";
    fill_under_busy();
    wait_drain();

    test_name = "random_mix";
    run_random(NUM_RANDOM);
    wait_drain();

    if (i_mem_queue_top.i_fifo_queue.i_mem_queue_chk.error_count == 0)
    begin
        $display("*** TEST PASSED ***");
        $finish;
    end
    else
    begin
        fail_and_stop("a queue assertion failed");
    end
end

endmodule

//--- mem_queue.f
+incdir+.
mem_request_pkg.sv
mem_response_pkg.sv
fifo_queue.sv
request_packer.sv
scratchpad_memory.sv
mem_queue_top.sv
mem_queue_chk.sv
mem_queue_tb.sv
